/* project.f */
rtl/bp_pkg.sv
rtl/bp_update_arbiter.sv
rtl/bp_bht.sv
rtl/bp_btb.sv
rtl/bp_next_pc.sv
rtl/bp_frontend_predictor.sv
verif/bp_tb_clock.sv
verif/bp_tb.sv

/* rtl/bp_bht.sv */
// flip-flop history table with async read; NrEntries must be a power of two, at least 4
`default_nettype none

module bp_bht #(
  parameter int unsigned NrEntries = 1024
) (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            flush_i,
  input  logic                                            clear_i,
  input  bp_pkg::vaddr_t                                  vpc_i,
  input  bp_pkg::bp_update_t                              upd_i,
  output bp_pkg::bht_pred_t [bp_pkg::INSTR_PER_FETCH-1:0] bht_pred_o
);

  localparam int unsigned NrRows   = NrEntries / bp_pkg::INSTR_PER_FETCH;
  localparam int unsigned SlotBits = $clog2(bp_pkg::INSTR_PER_FETCH);
  localparam int unsigned RowBits  = $clog2(NrRows);
  localparam int unsigned RowLsb   = bp_pkg::SLOT_OFFSET + SlotBits;

  typedef struct packed {
    logic             valid;
    bp_pkg::sat_cnt_t cnt;
  } bht_entry_t;

  bht_entry_t         bht_q [NrRows][bp_pkg::INSTR_PER_FETCH];
  logic [RowBits-1:0] rd_row;
  logic [RowBits-1:0] wr_row;
  logic [SlotBits-1:0] wr_slot;
  bht_entry_t         wr_old;
  bp_pkg::sat_cnt_t   cnt_next;

  // ----------------------------------------------------------------------
  // indexing
  // ----------------------------------------------------------------------
  // row comes from the bits above the slot select, wrapping at the depth
  assign rd_row  = vpc_i[RowLsb +: RowBits];
  assign wr_row  = upd_i.pc[RowLsb +: RowBits];
  assign wr_slot = upd_i.pc[bp_pkg::SLOT_OFFSET +: SlotBits];

  // ----------------------------------------------------------------------
  // lookup
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < bp_pkg::INSTR_PER_FETCH; i++) begin : gen_pred
    assign bht_pred_o[i].valid = bht_q[rd_row][i].valid;
    // upper counter bit is the taken prediction
    assign bht_pred_o[i].taken = bht_q[rd_row][i].cnt[1];
  end

  // ----------------------------------------------------------------------
  // counter update
  // ----------------------------------------------------------------------
  always_comb begin
    wr_old   = bht_q[wr_row][wr_slot];
    cnt_next = wr_old.cnt;
    if (upd_i.taken) begin
      if (wr_old.cnt != 2'b11) begin
        cnt_next = wr_old.cnt + 2'd1;
      end
    end else begin
      if (wr_old.cnt != 2'b00) begin
        cnt_next = wr_old.cnt - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned r = 0; r < NrRows; r++) begin
        for (int unsigned s = 0; s < bp_pkg::INSTR_PER_FETCH; s++) begin
          bht_q[r][s] <= '0;
        end
      end
    end else if (flush_i || clear_i) begin
      // flush wins over a write in the same cycle
      for (int unsigned r = 0; r < NrRows; r++) begin
        for (int unsigned s = 0; s < bp_pkg::INSTR_PER_FETCH; s++) begin
          bht_q[r][s] <= '0;
        end
      end
    end else if (upd_i.valid) begin
      bht_q[wr_row][wr_slot].valid <= 1'b1;
      bht_q[wr_row][wr_slot].cnt   <= cnt_next;
    end
  end

  // row indexing relies on an exact power-of-two split into two-slot rows
  a_depth: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (NrEntries >= 4) && ((NrEntries & (NrEntries - 1)) == 0));

endmodule

`default_nettype wire

/* rtl/bp_btb.sv */
// index-only target buffer with async read, no tags so aliasing rows simply overwrite
`default_nettype none

module bp_btb #(
  parameter int unsigned NrEntries = 64
) (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            flush_i,
  input  logic                                            clear_i,
  input  bp_pkg::vaddr_t                                  vpc_i,
  input  bp_pkg::bp_update_t                              upd_i,
  output bp_pkg::btb_pred_t [bp_pkg::INSTR_PER_FETCH-1:0] btb_pred_o
);

  localparam int unsigned NrRows   = NrEntries / bp_pkg::INSTR_PER_FETCH;
  localparam int unsigned SlotBits = $clog2(bp_pkg::INSTR_PER_FETCH);
  localparam int unsigned RowBits  = $clog2(NrRows);
  localparam int unsigned RowLsb   = bp_pkg::SLOT_OFFSET + SlotBits;

  logic [bp_pkg::INSTR_PER_FETCH-1:0] valid_q  [NrRows];
  bp_pkg::vaddr_t                     target_q [NrRows][bp_pkg::INSTR_PER_FETCH];
  logic [RowBits-1:0]                 rd_row;
  logic [RowBits-1:0]                 wr_row;
  logic [SlotBits-1:0]                wr_slot;
  logic                               wr_en;

  // same row and slot split as the history table
  assign rd_row  = vpc_i[RowLsb +: RowBits];
  assign wr_row  = upd_i.pc[RowLsb +: RowBits];
  assign wr_slot = upd_i.pc[bp_pkg::SLOT_OFFSET +: SlotBits];

  // only taken branches carry a useful target
  assign wr_en = upd_i.valid && upd_i.taken;

  // ----------------------------------------------------------------------
  // lookup
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < bp_pkg::INSTR_PER_FETCH; i++) begin : gen_pred
    assign btb_pred_o[i].valid  = valid_q[rd_row][i];
    assign btb_pred_o[i].target = target_q[rd_row][i];
  end

  // ----------------------------------------------------------------------
  // storage
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned r = 0; r < NrRows; r++) begin
        valid_q[r] <= '0;
      end
    end else if (flush_i || clear_i) begin
      for (int unsigned r = 0; r < NrRows; r++) begin
        valid_q[r] <= '0;
      end
    end else if (wr_en) begin
      valid_q[wr_row][wr_slot] <= 1'b1;
    end
  end

  // target is only looked at when its valid bit is set
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      target_q[wr_row][wr_slot] <= upd_i.target;
    end
  end

endmodule

`default_nettype wire

/* rtl/bp_frontend_predictor.sv */
// predictor top; table depths must be powers of two, lookups answer in the same cycle
`default_nettype none

module bp_frontend_predictor #(
  parameter int unsigned NrBhtEntries = 1024,
  parameter int unsigned NrBtbEntries = 64
) (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            flush_i,
  input  logic                                            clear_i,
  input  logic                                            debug_mode_i,
  input  bp_pkg::vaddr_t                                  vpc_i,
  // branch unit resolve port
  input  logic                                            req0_i,
  input  bp_pkg::bp_update_t                              upd0_i,
  output logic                                            ack0_o,
  // jump unit resolve port
  input  logic                                            req1_i,
  input  bp_pkg::bp_update_t                              upd1_i,
  output logic                                            ack1_o,
  output bp_pkg::bht_pred_t [bp_pkg::INSTR_PER_FETCH-1:0] bht_pred_o,
  output bp_pkg::fetch_pred_t                             fetch_pred_o
);

  bp_pkg::bp_update_t                              upd_bus;
  bp_pkg::btb_pred_t [bp_pkg::INSTR_PER_FETCH-1:0] btb_pred;

  // ----------------------------------------------------------------------
  // update path
  // ----------------------------------------------------------------------
  bp_update_arbiter i_bp_update_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .debug_mode_i (debug_mode_i),
    .req0_i       (req0_i),
    .req1_i       (req1_i),
    .upd0_i       (upd0_i),
    .upd1_i       (upd1_i),
    .ack0_o       (ack0_o),
    .ack1_o       (ack1_o),
    .upd_o        (upd_bus)
  );

  // ----------------------------------------------------------------------
  // tables and merge
  // ----------------------------------------------------------------------
  bp_bht #(
    .NrEntries (NrBhtEntries)
  ) i_bp_bht (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .clear_i    (clear_i),
    .vpc_i      (vpc_i),
    .upd_i      (upd_bus),
    .bht_pred_o (bht_pred_o)
  );

  bp_btb #(
    .NrEntries (NrBtbEntries)
  ) i_bp_btb (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .clear_i    (clear_i),
    .vpc_i      (vpc_i),
    .upd_i      (upd_bus),
    .btb_pred_o (btb_pred)
  );

  bp_next_pc i_bp_next_pc (
    .vpc_i        (vpc_i),
    .bht_pred_i   (bht_pred_o),
    .btb_pred_i   (btb_pred),
    .fetch_pred_o (fetch_pred_o)
  );

endmodule

`default_nettype wire

/* rtl/bp_next_pc.sv */
// purely combinational merge; lowest qualifying slot at or after the fetch start slot wins
`default_nettype none

module bp_next_pc (
  input  bp_pkg::vaddr_t                                  vpc_i,
  input  bp_pkg::bht_pred_t [bp_pkg::INSTR_PER_FETCH-1:0] bht_pred_i,
  input  bp_pkg::btb_pred_t [bp_pkg::INSTR_PER_FETCH-1:0] btb_pred_i,
  output bp_pkg::fetch_pred_t                             fetch_pred_o
);

  localparam int unsigned SlotBits   = $clog2(bp_pkg::INSTR_PER_FETCH);
  // bytes covered by one fetch block
  localparam int unsigned FetchBytes = bp_pkg::INSTR_PER_FETCH * (2 ** bp_pkg::SLOT_OFFSET);

  logic [SlotBits-1:0]                start_slot;
  logic [bp_pkg::INSTR_PER_FETCH-1:0] hit;
  bp_pkg::vaddr_t                     seq_pc;

  assign start_slot = vpc_i[bp_pkg::SLOT_OFFSET +: SlotBits];

  // fall-through is the start of the next fetch block
  assign seq_pc = (vpc_i & ~bp_pkg::vaddr_t'(FetchBytes - 1)) + bp_pkg::vaddr_t'(FetchBytes);

  // ----------------------------------------------------------------------
  // per-slot qualification
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < bp_pkg::INSTR_PER_FETCH; i++) begin : gen_hit
    // slots before the fetch entry point were not executed
    assign hit[i] = (i >= start_slot)
                    && bht_pred_i[i].valid && bht_pred_i[i].taken
                    && btb_pred_i[i].valid;
  end

  // ----------------------------------------------------------------------
  // priority select
  // ----------------------------------------------------------------------
  always_comb begin
    fetch_pred_o.redirect = 1'b0;
    fetch_pred_o.next_pc  = seq_pc;
    for (int unsigned i = 0; i < bp_pkg::INSTR_PER_FETCH; i++) begin
      if (hit[i] && !fetch_pred_o.redirect) begin
        fetch_pred_o.redirect = 1'b1;
        fetch_pred_o.next_pc  = btb_pred_i[i].target;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/bp_pkg.sv */
// fetch geometry and predictor types; assumes 32-bit virtual addresses and two halfword slots
`default_nettype none

package bp_pkg;

  // ----------------------------------------------------------------------
  // fetch geometry
  // ----------------------------------------------------------------------
  // instruction slots per 4-byte fetch block
  localparam int unsigned INSTR_PER_FETCH = 2;
  // pc bit 0 is never used for indexing (halfword alignment)
  localparam int unsigned SLOT_OFFSET = 1;

  // ----------------------------------------------------------------------
  // basic types
  // ----------------------------------------------------------------------
  typedef logic [31:0] vaddr_t;
  // 0 and 1 predict not taken, 2 and 3 predict taken
  typedef logic [1:0] sat_cnt_t;

  // resolved branch from execute, also used on the table update bus
  typedef struct packed {
    logic   valid;
    vaddr_t pc;
    logic   taken;
    vaddr_t target;
  } bp_update_t;

  // per-slot history table result
  typedef struct packed {
    logic valid;
    logic taken;
  } bht_pred_t;

  // per-slot target buffer result
  typedef struct packed {
    logic   valid;
    vaddr_t target;
  } btb_pred_t;

  // combined next fetch decision
  typedef struct packed {
    logic   redirect;
    vaddr_t next_pc;
  } fetch_pred_t;

  // four-phase endpoint state
  typedef enum logic [1:0] {
    IDLE,
    ACK_HIGH,
    WAIT_LOW
  } arb_state_e;

endpackage

`default_nettype wire

/* rtl/bp_update_arbiter.sv */
// two four-phase ports, req sampled one cycle before arbitration; debug mode drops the write
`default_nettype none

module bp_update_arbiter (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               debug_mode_i,
  input  logic               req0_i,
  input  logic               req1_i,
  input  bp_pkg::bp_update_t upd0_i,
  input  bp_pkg::bp_update_t upd1_i,
  output logic               ack0_o,
  output logic               ack1_o,
  output bp_pkg::bp_update_t upd_o
);

  localparam int unsigned NrPorts = 2;

  logic               [NrPorts-1:0] req;
  logic               [NrPorts-1:0] req_q;
  bp_pkg::bp_update_t [NrPorts-1:0] upd_in;
  bp_pkg::arb_state_e               state_q [NrPorts];
  bp_pkg::arb_state_e               state_d [NrPorts];
  logic               [NrPorts-1:0] cand;
  logic               [NrPorts-1:0] gnt;
  logic               [NrPorts-1:0] ack;
  // port that wins when both ask in the same cycle
  logic                             prio_q;

  assign req    = {req1_i, req0_i};
  assign upd_in = {upd1_i, upd0_i};
  assign ack0_o = ack[0];
  assign ack1_o = ack[1];

  // ----------------------------------------------------------------------
  // round-robin grant
  // ----------------------------------------------------------------------
  always_comb begin
    gnt = cand;
    if (cand[0] && cand[1]) begin
      gnt         = '0;
      gnt[prio_q] = 1'b1;
    end
  end

  // winner goes straight onto the table bus, tables write at the next edge
  always_comb begin
    upd_o       = gnt[1] ? upd_in[1] : upd_in[0];
    upd_o.valid = (|gnt) && !debug_mode_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q <= 1'b0;
      req_q  <= '0;
    end else begin
      req_q <= req;
      // hand priority to the port that just lost out
      if (gnt[0]) begin
        prio_q <= 1'b1;
      end else if (gnt[1]) begin
        prio_q <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------------------
  // per-port handshake
  // ----------------------------------------------------------------------
  for (genvar p = 0; p < NrPorts; p++) begin : gen_port
    assign cand[p] = (state_q[p] == bp_pkg::IDLE) && req_q[p];
    assign ack[p]  = (state_q[p] == bp_pkg::ACK_HIGH);

    always_comb begin
      state_d[p] = state_q[p];
      unique case (state_q[p])
        bp_pkg::IDLE: begin
          if (gnt[p]) begin
            state_d[p] = bp_pkg::ACK_HIGH;
          end
        end
        // hold ack until the source has dropped req
        bp_pkg::ACK_HIGH: begin
          if (!req_q[p]) begin
            state_d[p] = bp_pkg::WAIT_LOW;
          end
        end
        // return-to-zero, one cycle before a new request can be taken
        bp_pkg::WAIT_LOW: begin
          if (!req_q[p]) begin
            state_d[p] = bp_pkg::IDLE;
          end
        end
        default: state_d[p] = bp_pkg::IDLE;
      endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        state_q[p] <= bp_pkg::IDLE;
      end else begin
        state_q[p] <= state_d[p];
      end
    end

    // ack only answers a live request
    a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(ack[p]) |-> req[p]);
    // the source must hold its payload until the handshake completes
    a_upd_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (req[p] && !ack[p]) |=> $stable(upd_in[p]));
  end

endmodule

`default_nettype wire

/* verif/bp_tb.sv */
// small table depths so rows alias; stops at the first error, handshakes must not overlap phases
`default_nettype none

module bp_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned NrBht       = 16;
  localparam int unsigned NrBtb       = 8;
  localparam int unsigned ResetCycles = 16;
  localparam int unsigned SatTxn      = 12;
  localparam int unsigned RandTxn     = 20;
  localparam int unsigned ContRounds  = 12;
  localparam int unsigned DbgTxn      = 6;
  localparam int unsigned RebuildTxn  = 6;
  localparam int unsigned TotalTxn    = SatTxn + 2 * RandTxn + 3 * ContRounds
                                        + 2 * DbgTxn + 4 * RebuildTxn;
  localparam int unsigned TimeoutCycles = ResetCycles + 20 * TotalTxn;

  logic                                            clk;
  logic                                            rst_n;
  logic                                            flush;
  logic                                            clear;
  logic                                            debug_mode;
  bp_pkg::vaddr_t                                  vpc;
  logic                                            req [2];
  bp_pkg::bp_update_t                              upd [2];
  logic                                            ack0;
  logic                                            ack1;
  logic [1:0]                                      ack;
  logic [1:0]                                      ack_q;
  bp_pkg::bht_pred_t [bp_pkg::INSTR_PER_FETCH-1:0] bht_pred;
  bp_pkg::fetch_pred_t                             fetch_pred;

  // reference model of both tables
  bp_pkg::sat_cnt_t m_cnt    [NrBht];
  logic             m_bvalid [NrBht];
  logic             m_tvalid [NrBtb];
  bp_pkg::vaddr_t   m_tgt    [NrBtb];
  // one random stream per driver and one for the lookup process
  logic [31:0]      rng_state [3];
  // edge on which each driver last saw its ack
  time              ack_time [2];

  assign ack = {ack1, ack0};

  bp_tb_clock #(
    .ResetCycles (ResetCycles)
  ) i_bp_tb_clock (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  bp_frontend_predictor #(
    .NrBhtEntries (NrBht),
    .NrBtbEntries (NrBtb)
  ) i_bp_frontend_predictor (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .flush_i      (flush),
    .clear_i      (clear),
    .debug_mode_i (debug_mode),
    .vpc_i        (vpc),
    .req0_i       (req[0]),
    .upd0_i       (upd[0]),
    .ack0_o       (ack0),
    .req1_i       (req[1]),
    .upd1_i       (upd[1]),
    .ack1_o       (ack1),
    .bht_pred_o   (bht_pred),
    .fetch_pred_o (fetch_pred)
  );

  // ----------------------------------------------------------------------
  // random numbers and reporting
  // ----------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_word(input int unsigned s);
    rng_state[s] = xorshift32(rng_state[s]);
    return rng_state[s];
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      report_failure($sformatf("mismatch at %0t: %s actual %0h expected %0h",
                               $time, name, actual, expected));
    end
  endtask

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------
  // halfword entry number, wrapped at the table depth
  function automatic int unsigned entry_index(input bp_pkg::vaddr_t addr,
                                              input int unsigned depth);
    return (addr >> 1) % depth;
  endfunction

  function automatic void model_update(input bp_pkg::bp_update_t u);
    int unsigned bi;
    int unsigned ti;
    bi = entry_index(u.pc, NrBht);
    ti = entry_index(u.pc, NrBtb);
    if (u.taken) begin
      if (m_cnt[bi] != 2'd3) m_cnt[bi] = m_cnt[bi] + 2'd1;
      m_tvalid[ti] = 1'b1;
      m_tgt[ti]    = u.target;
    end else begin
      if (m_cnt[bi] != 2'd0) m_cnt[bi] = m_cnt[bi] - 2'd1;
    end
    m_bvalid[bi] = 1'b1;
  endfunction

  function automatic void model_clear();
    for (int i = 0; i < NrBht; i++) begin
      m_cnt[i]    = 2'd0;
      m_bvalid[i] = 1'b0;
    end
    for (int i = 0; i < NrBtb; i++) begin
      m_tvalid[i] = 1'b0;
    end
  endfunction

  function automatic bp_pkg::bp_update_t random_update(input int unsigned s);
    bp_pkg::bp_update_t u;
    u.valid  = 1'b1;
    u.pc     = rand_word(s) & ~32'h1;
    // mostly taken so that redirects show up often
    u.taken  = (rand_word(s) & 32'h3) != 0;
    u.target = rand_word(s) & ~32'h1;
    return u;
  endfunction

  // ----------------------------------------------------------------------
  // drivers and lookups
  // ----------------------------------------------------------------------
  // one full four-phase handshake; the model follows on the edge ack is seen
  task automatic send_update(input int unsigned p, input bp_pkg::bp_update_t u);
    @(posedge clk);
    req[p] <= 1'b1;
    upd[p] <= u;
    @(posedge clk);
    while (!ack[p]) @(posedge clk);
    ack_time[p] = $time;
    if (!debug_mode) model_update(u);
    req[p] <= 1'b0;
    @(posedge clk);
    while (ack[p]) @(posedge clk);
  endtask

  task automatic drive_random(input int unsigned p, input int unsigned count,
                              input int unsigned max_gap);
    int unsigned gap;
    for (int n = 0; n < count; n++) begin
      gap = rand_word(p) % (max_gap + 1);
      repeat (gap) @(posedge clk);
      send_update(p, random_update(p));
    end
  endtask

  task automatic check_lookup(input bp_pkg::vaddr_t pc);
    int unsigned    bi;
    int unsigned    ti;
    logic           exp_redirect;
    bp_pkg::vaddr_t exp_next;
    @(posedge clk);
    vpc <= pc;
    @(negedge clk);
    exp_redirect = 1'b0;
    exp_next     = (pc & ~32'h3) + 32'd4;
    for (int s = 0; s < 2; s++) begin
      bi = entry_index((pc & ~32'h3) + 2 * s, NrBht);
      ti = entry_index((pc & ~32'h3) + 2 * s, NrBtb);
      check_equal($sformatf("bht_pred_o[%0d].valid", s), bht_pred[s].valid, m_bvalid[bi]);
      check_equal($sformatf("bht_pred_o[%0d].taken", s), bht_pred[s].taken, m_cnt[bi][1]);
      // first taken slot at or after the entry point with a known target
      if (!exp_redirect && s >= pc[1] && m_bvalid[bi] && m_cnt[bi][1] && m_tvalid[ti]) begin
        exp_redirect = 1'b1;
        exp_next     = m_tgt[ti];
      end
    end
    check_equal("fetch_pred_o.redirect", fetch_pred.redirect, exp_redirect);
    check_equal("fetch_pred_o.next_pc", fetch_pred.next_pc, exp_next);
  endtask

  // every entry and both start slots of one 32-byte window
  task automatic sweep_rows(input bp_pkg::vaddr_t base);
    for (int k = 0; k < 16; k++) begin
      check_lookup((base & ~32'h1f) + 2 * k);
    end
  endtask

  task automatic pulse_clear(input logic use_flush);
    @(posedge clk);
    if (use_flush) flush <= 1'b1;
    else clear <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    clear <= 1'b0;
    model_clear();
  endtask

  // ----------------------------------------------------------------------
  // monitors
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    if (rst_n) begin
      for (int p = 0; p < 2; p++) begin
        if (ack[p] && !ack_q[p] && !req[p]) begin
          report_failure($sformatf("ack on port %0d rose while its request was low", p));
        end
      end
    end
    ack_q <= ack;
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk);
    report_failure($sformatf("timeout after %0d cycles, a handshake never finished",
                             TimeoutCycles));
  end

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin
    bp_pkg::bp_update_t u;
    bp_pkg::vaddr_t     sat_pc;
    bp_pkg::vaddr_t     sat_tgt;
    rng_state[0] = 32'h3839252f;
    rng_state[1] = 32'h3839252f ^ 32'h9e3779b9;
    rng_state[2] = 32'h3839252f ^ 32'h7f4a7c15;
    flush        = 1'b0;
    clear        = 1'b0;
    debug_mode   = 1'b0;
    vpc          = '0;
    ack_q        = '0;
    for (int p = 0; p < 2; p++) begin
      req[p]      = 1'b0;
      upd[p]      = '0;
      ack_time[p] = 0;
    end
    model_clear();
    wait (rst_n === 1'b1);

    // reset state
    check_equal("ack0_o", ack0, 1'b0);
    check_equal("ack1_o", ack1, 1'b0);
    sweep_rows(rand_word(2));
    repeat (16) check_lookup(rand_word(2) & ~32'h1);

    // counter walks up to 3, down to 0 and back, holding at both ends
    sat_pc  = rand_word(2) & ~32'h1;
    sat_tgt = rand_word(2) & ~32'h1;
    for (int n = 0; n < SatTxn; n++) begin
      u.valid  = 1'b1;
      u.pc     = sat_pc;
      u.taken  = (n < 5) || (n == SatTxn - 1);
      u.target = sat_tgt;
      send_update(0, u);
      check_lookup(sat_pc);
    end

    // random traffic from both ports, then redirect selection
    fork
      drive_random(0, RandTxn, 3);
      drive_random(1, RandTxn, 3);
    join
    sweep_rows(rand_word(2));
    repeat (32) check_lookup(rand_word(2) & ~32'h1);

    // a lone grant moves priority to the other port
    // then both ports raise req on the same edge
    for (int r = 0; r < ContRounds; r++) begin
      send_update(r % 2, random_update(r % 2));
      fork
        send_update(0, random_update(0));
        send_update(1, random_update(1));
      join
      if (ack_time[0] == ack_time[1]) begin
        report_failure("both ports were acknowledged on the same edge");
      end
      check_equal("first granted port", ack_time[1] < ack_time[0], 1 - r % 2);
      sweep_rows(rand_word(2));
    end

    // debug mode drops the writes but still completes the handshakes
    @(posedge clk);
    debug_mode <= 1'b1;
    fork
      drive_random(0, DbgTxn, 2);
      drive_random(1, DbgTxn, 2);
    join
    @(posedge clk);
    debug_mode <= 1'b0;
    sweep_rows(rand_word(2));

    // flush, then clear, each followed by a rebuild
    for (int k = 0; k < 2; k++) begin
      pulse_clear(k == 0);
      sweep_rows(rand_word(2));
      fork
        drive_random(0, RebuildTxn, 2);
        drive_random(1, RebuildTxn, 2);
      join
      sweep_rows(rand_word(2));
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/bp_tb_clock.sv */
// free-running 4 ns clock; reset is released with a non-blocking write on a rising edge
`default_nettype none

module bp_tb_clock #(
  parameter int unsigned ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // active-low reset held for the first cycles
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire
